// File: src/cache_pkg.sv
package cache_pkg;

    //////////////////////////////////////////////////
    // cache geometry
    //////////////////////////////////////////////////

    localparam int WORD_SIZE  = 32;   // data word and address width
    localparam int LINE_BYTES = 16;
    localparam int LINE_WORDS = LINE_BYTES / 4;
    localparam int NUM_LINES  = 16;   // direct mapped, one way

    //////////////////////////////////////////////////
    // address split: | tag | index | offset |
    //////////////////////////////////////////////////

    localparam int OFFSET_BITS = $clog2(LINE_BYTES);  // byte within line
    localparam int INDEX_BITS  = $clog2(NUM_LINES);   // line select
    localparam int TAG_BITS    = WORD_SIZE - INDEX_BITS - OFFSET_BITS;

    // one whole line as a flat vector, byte 0 at the low end
    localparam int LINE_BITS = LINE_BYTES * 8;

endpackage : cache_pkg

// File: src/memop_pkg.sv
package memop_pkg;

    // access size of a cpu load or store
    // the cpu drives it on cpu_size_i, the data array
    // uses it for byte enables and load extraction
    typedef enum logic [1:0] {
        MEM_BYTE = 2'b00,   // 8 bits
        MEM_HALF = 2'b01,   // 16 bits, half aligned
        MEM_WORD = 2'b10    // 32 bits, word aligned
    } memop_size_e;

endpackage : memop_pkg

// File: src/cache_tags.sv
`timescale 1ns/10ps

module cache_tags import cache_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rsn_i,

    input  logic [INDEX_BITS-1:0] index_i,
    input  logic [TAG_BITS-1:0]   tag_i,
    input  logic                  fill_i,       // line refilled from memory
    input  logic                  set_dirty_i,  // store hit

    output logic                  hit_o,
    output logic                  dirty_o,
    output logic [TAG_BITS-1:0]   victim_tag_o
);

    logic [TAG_BITS-1:0]  tag_q [NUM_LINES];
    logic [NUM_LINES-1:0] valid_q;
    logic [NUM_LINES-1:0] dirty_q;

    // lookup of the indexed line
    assign hit_o        = valid_q[index_i] && (tag_q[index_i] == tag_i);
    assign dirty_o      = dirty_q[index_i];
    assign victim_tag_o = tag_q[index_i];  // for the writeback address

    // valid and dirty state
    always_ff @(posedge clk_i, negedge rsn_i) begin
        if (!rsn_i) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            if (fill_i) begin
                valid_q[index_i] <= 1'b1;
                dirty_q[index_i] <= 1'b0;  // fresh copy of memory
            end else if (set_dirty_i) begin
                dirty_q[index_i] <= 1'b1;
            end
        end
    end

    // tag array
    always_ff @(posedge clk_i) begin
        if (fill_i) begin
            tag_q[index_i] <= tag_i;
        end
    end

endmodule : cache_tags

// File: src/cache_data.sv
`timescale 1ns/10ps

module cache_data import cache_pkg::*; import memop_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rsn_i,

    input  logic [INDEX_BITS-1:0]  index_i,
    input  logic [OFFSET_BITS-1:0] offset_i,
    input  memop_size_e            size_i,

    input  logic                   wr_word_i,   // sized store into the line
    input  logic [WORD_SIZE-1:0]   wdata_i,
    input  logic                   fill_i,      // whole line from memory
    input  logic [LINE_BITS-1:0]   fill_line_i,

    output logic [WORD_SIZE-1:0]   rdata_o,     // zero extended load value
    output logic [LINE_BITS-1:0]   line_o
);

    logic [LINE_BITS-1:0]  lines_q [NUM_LINES];

    logic [LINE_BYTES-1:0] size_mask;
    logic [LINE_BYTES-1:0] byte_en;
    logic [WORD_SIZE-1:0]  wr_word;
    logic [LINE_BITS-1:0]  wr_line;
    logic [WORD_SIZE-1:0]  rd_word;
    logic [WORD_SIZE-1:0]  rd_shift;

    assign line_o = lines_q[index_i];

    //////////////////////////////////////////////////
    // store path
    //////////////////////////////////////////////////

    // accesses are aligned, so replicating the store data across the
    // line puts every byte in its lane and the enables pick the right ones
    always_comb begin
        case (size_i)
            MEM_BYTE: begin
                size_mask = LINE_BYTES'(4'b0001);
                wr_word   = {4{wdata_i[7:0]}};
            end
            MEM_HALF: begin
                size_mask = LINE_BYTES'(4'b0011);
                wr_word   = {2{wdata_i[15:0]}};
            end
            default: begin
                size_mask = LINE_BYTES'(4'b1111);
                wr_word   = wdata_i;
            end
        endcase
    end

    assign byte_en = size_mask << offset_i;
    assign wr_line = {LINE_WORDS{wr_word}};

    always_ff @(posedge clk_i, negedge rsn_i) begin
        if (!rsn_i) begin
            for (int i = 0; i < NUM_LINES; i++) begin
                lines_q[i] <= '0;
            end
        end else if (fill_i) begin
            lines_q[index_i] <= fill_line_i;
        end else if (wr_word_i) begin
            for (int b = 0; b < LINE_BYTES; b++) begin
                if (byte_en[b]) begin
                    lines_q[index_i][8*b +: 8] <= wr_line[8*b +: 8];
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // load path
    //////////////////////////////////////////////////

    assign rd_word  = line_o[WORD_SIZE*offset_i[OFFSET_BITS-1:2] +: WORD_SIZE];
    assign rd_shift = rd_word >> {offset_i[1:0], 3'b000};  // byte lane to bit 0

    always_comb begin
        case (size_i)
            MEM_BYTE: rdata_o = {24'b0, rd_shift[7:0]};
            MEM_HALF: rdata_o = {16'b0, rd_shift[15:0]};
            default:  rdata_o = rd_shift;
        endcase
    end

endmodule : cache_data

// File: src/cache_ctrl.sv
`timescale 1ns/10ps

module cache_ctrl import cache_pkg::*; import memop_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rsn_i,

    // cpu wishbone slave
    input  logic                   cpu_cyc_i,
    input  logic                   cpu_stb_i,
    input  logic                   cpu_we_i,
    input  logic [WORD_SIZE-1:0]   cpu_adr_i,
    input  logic [WORD_SIZE-1:0]   cpu_dat_i,
    input  memop_size_e            cpu_size_i,
    output logic                   cpu_ack_o,
    output logic [WORD_SIZE-1:0]   cpu_dat_o,

    // tags and data array
    output logic [INDEX_BITS-1:0]  index_o,
    output logic [TAG_BITS-1:0]    tag_o,
    output logic [OFFSET_BITS-1:0] offset_o,
    output memop_size_e            size_o,
    output logic [WORD_SIZE-1:0]   wdata_o,
    output logic                   tag_fill_o,
    output logic                   set_dirty_o,
    output logic                   wr_word_o,
    output logic                   data_fill_o,
    input  logic                   hit_i,
    input  logic                   dirty_i,
    input  logic [TAG_BITS-1:0]    victim_tag_i,
    input  logic [WORD_SIZE-1:0]   rdata_i,

    // line master
    output logic                   line_start_o,
    output logic                   line_write_o,
    output logic [WORD_SIZE-1:0]   line_addr_o,
    input  logic                   line_done_i
);

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        ACCESS,
        WRITEBACK,
        REFILL,
        RESPOND
    } ctrl_state_e;

    ctrl_state_e state_q;
    ctrl_state_e state_d;

    logic                 req_start;
    logic                 req_we;
    logic [WORD_SIZE-1:0] req_adr;
    logic [WORD_SIZE-1:0] req_dat;
    memop_size_e          req_size;
    logic [WORD_SIZE-1:0] load_q;
    logic                 refill_done;

    assign req_start = (state_q == IDLE) && cpu_cyc_i && cpu_stb_i;

    //////////////////////////////////////////////////
    // request register
    //////////////////////////////////////////////////

    // captured on entry, held through lookup and any miss handling
    always_ff @(posedge clk_i) begin
        if (req_start) begin
            req_we   <= cpu_we_i;
            req_adr  <= cpu_adr_i;
            req_dat  <= cpu_dat_i;
            req_size <= cpu_size_i;
        end
        if (state_q == ACCESS) begin
            load_q <= rdata_i;
        end
    end

    assign offset_o = req_adr[OFFSET_BITS-1:0];
    assign index_o  = req_adr[OFFSET_BITS +: INDEX_BITS];
    assign tag_o    = req_adr[WORD_SIZE-1 -: TAG_BITS];
    assign size_o   = req_size;
    assign wdata_o  = req_dat;

    //////////////////////////////////////////////////
    // fsm
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i, negedge rsn_i) begin
        if (!rsn_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:      if (req_start) state_d = LOOKUP;
            LOOKUP: begin
                if (hit_i)        state_d = ACCESS;
                else if (dirty_i) state_d = WRITEBACK;  // evict victim first
                else              state_d = REFILL;
            end
            WRITEBACK: if (line_done_i) state_d = REFILL;
            REFILL:    if (line_done_i) state_d = ACCESS;
            ACCESS:    state_d = RESPOND;
            RESPOND:   state_d = IDLE;
            default:   state_d = IDLE;
        endcase
    end

    // line transfers: writeback starts from lookup, refill from lookup or
    // straight after the writeback finishes
    assign line_start_o = ((state_q == LOOKUP) && !hit_i) ||
                          ((state_q == WRITEBACK) && line_done_i);
    assign line_write_o = (state_q == LOOKUP) && dirty_i;
    assign line_addr_o  = line_write_o ? {victim_tag_i, index_o, {OFFSET_BITS{1'b0}}}
                                       : {tag_o, index_o, {OFFSET_BITS{1'b0}}};

    assign refill_done = (state_q == REFILL) && line_done_i;
    assign tag_fill_o  = refill_done;
    assign data_fill_o = refill_done;

    assign wr_word_o   = (state_q == ACCESS) && req_we;
    assign set_dirty_o = (state_q == ACCESS) && req_we;

    assign cpu_ack_o = (state_q == RESPOND);  // one cycle, cpu must take it
    assign cpu_dat_o = load_q;

endmodule : cache_ctrl

// File: src/wb_line_master.sv
`timescale 1ns/10ps

module wb_line_master import cache_pkg::*; (
    input  logic                 clk_i,
    input  logic                 rsn_i,

    input  logic                 line_start_i,
    input  logic                 line_write_i,
    input  logic [WORD_SIZE-1:0] line_addr_i,   // line base address
    input  logic [LINE_BITS-1:0] line_wdata_i,
    output logic                 line_done_o,
    output logic [LINE_BITS-1:0] line_rdata_o,

    // memory wishbone master
    output logic                 mem_cyc_o,
    output logic                 mem_stb_o,
    output logic                 mem_we_o,
    output logic [WORD_SIZE-1:0] mem_adr_o,
    output logic [WORD_SIZE-1:0] mem_dat_o,
    input  logic [WORD_SIZE-1:0] mem_dat_i,
    input  logic                 mem_ack_i
);

    logic                   active_q;   // line transfer in progress
    logic                   stb_q;      // word cycle on the bus
    logic                   done_q;
    logic [OFFSET_BITS-3:0] word_q;     // word within the line
    logic                   write_q;
    logic [WORD_SIZE-1:0]   addr_q;
    logic [LINE_BITS-1:0]   wdata_q;
    logic [LINE_BITS-1:0]   rdata_q;

    // control
    always_ff @(posedge clk_i, negedge rsn_i) begin
        if (!rsn_i) begin
            active_q <= 1'b0;
            stb_q    <= 1'b0;
            done_q   <= 1'b0;
            word_q   <= '0;
        end else begin
            done_q <= 1'b0;
            if (line_start_i && !active_q) begin
                active_q <= 1'b1;
                stb_q    <= 1'b1;
                word_q   <= '0;
            end else if (stb_q && mem_ack_i) begin
                stb_q <= 1'b0;  // one idle cycle between words
                if (word_q == (OFFSET_BITS-2)'(LINE_WORDS-1)) begin
                    active_q <= 1'b0;
                    done_q   <= 1'b1;
                end else begin
                    word_q <= word_q + 1'b1;
                end
            end else if (active_q && !stb_q) begin
                stb_q <= 1'b1;
            end
        end
    end

    // line payload
    always_ff @(posedge clk_i) begin
        if (line_start_i && !active_q) begin
            write_q <= line_write_i;
            addr_q  <= line_addr_i;
            wdata_q <= line_wdata_i;
        end
        if (stb_q && mem_ack_i && !write_q) begin
            rdata_q[WORD_SIZE*word_q +: WORD_SIZE] <= mem_dat_i;
        end
    end

    assign mem_cyc_o = stb_q;
    assign mem_stb_o = stb_q;
    assign mem_we_o  = stb_q && write_q;
    assign mem_adr_o = {addr_q[WORD_SIZE-1:OFFSET_BITS], word_q, 2'b00};
    assign mem_dat_o = wdata_q[WORD_SIZE*word_q +: WORD_SIZE];

    assign line_done_o  = done_q;
    assign line_rdata_o = rdata_q;

endmodule : wb_line_master

// File: src/dcache_top.sv
`timescale 1ns/10ps

module dcache_top import cache_pkg::*; import memop_pkg::*; (
    input  logic                 clk_i,
    input  logic                 rsn_i,

    // cpu port, wishbone slave
    input  logic                 cpu_cyc_i,
    input  logic                 cpu_stb_i,
    input  logic                 cpu_we_i,
    input  logic [WORD_SIZE-1:0] cpu_adr_i,
    input  logic [WORD_SIZE-1:0] cpu_dat_i,
    input  memop_size_e          cpu_size_i,
    output logic                 cpu_ack_o,
    output logic [WORD_SIZE-1:0] cpu_dat_o,

    // memory port, wishbone master
    output logic                 mem_cyc_o,
    output logic                 mem_stb_o,
    output logic                 mem_we_o,
    output logic [WORD_SIZE-1:0] mem_adr_o,
    output logic [WORD_SIZE-1:0] mem_dat_o,
    input  logic [WORD_SIZE-1:0] mem_dat_i,
    input  logic                 mem_ack_i
);

    logic [INDEX_BITS-1:0]  index;
    logic [TAG_BITS-1:0]    tag;
    logic [OFFSET_BITS-1:0] offset;
    memop_size_e            size;
    logic [WORD_SIZE-1:0]   wdata;
    logic                   tag_fill;
    logic                   set_dirty;
    logic                   wr_word;
    logic                   data_fill;
    logic                   hit;
    logic                   dirty;
    logic [TAG_BITS-1:0]    victim_tag;
    logic [WORD_SIZE-1:0]   rdata;
    logic [LINE_BITS-1:0]   line;       // indexed line, for writeback
    logic [LINE_BITS-1:0]   fill_line;  // line read from memory
    logic                   line_start;
    logic                   line_write;
    logic [WORD_SIZE-1:0]   line_addr;
    logic                   line_done;

    //////////////////////////////////////////////////
    // controller
    //////////////////////////////////////////////////

    cache_ctrl u_ctrl (
        .clk_i(clk_i),
        .rsn_i(rsn_i),
        .cpu_cyc_i(cpu_cyc_i),
        .cpu_stb_i(cpu_stb_i),
        .cpu_we_i(cpu_we_i),
        .cpu_adr_i(cpu_adr_i),
        .cpu_dat_i(cpu_dat_i),
        .cpu_size_i(cpu_size_i),
        .cpu_ack_o(cpu_ack_o),
        .cpu_dat_o(cpu_dat_o),
        .index_o(index),
        .tag_o(tag),
        .offset_o(offset),
        .size_o(size),
        .wdata_o(wdata),
        .tag_fill_o(tag_fill),
        .set_dirty_o(set_dirty),
        .wr_word_o(wr_word),
        .data_fill_o(data_fill),
        .hit_i(hit),
        .dirty_i(dirty),
        .victim_tag_i(victim_tag),
        .rdata_i(rdata),
        .line_start_o(line_start),
        .line_write_o(line_write),
        .line_addr_o(line_addr),
        .line_done_i(line_done)
    );

    //////////////////////////////////////////////////
    // storage and memory side
    //////////////////////////////////////////////////

    cache_tags u_tags (
        .clk_i(clk_i),
        .rsn_i(rsn_i),
        .index_i(index),
        .tag_i(tag),
        .fill_i(tag_fill),
        .set_dirty_i(set_dirty),
        .hit_o(hit),
        .dirty_o(dirty),
        .victim_tag_o(victim_tag)
    );

    cache_data u_data (
        .clk_i(clk_i),
        .rsn_i(rsn_i),
        .index_i(index),
        .offset_i(offset),
        .size_i(size),
        .wr_word_i(wr_word),
        .wdata_i(wdata),
        .fill_i(data_fill),
        .fill_line_i(fill_line),
        .rdata_o(rdata),
        .line_o(line)
    );

    wb_line_master u_line (
        .clk_i(clk_i),
        .rsn_i(rsn_i),
        .line_start_i(line_start),
        .line_write_i(line_write),
        .line_addr_i(line_addr),
        .line_wdata_i(line),
        .line_done_o(line_done),
        .line_rdata_o(fill_line),
        .mem_cyc_o(mem_cyc_o),
        .mem_stb_o(mem_stb_o),
        .mem_we_o(mem_we_o),
        .mem_adr_o(mem_adr_o),
        .mem_dat_o(mem_dat_o),
        .mem_dat_i(mem_dat_i),
        .mem_ack_i(mem_ack_i)
    );

endmodule : dcache_top

// File: bench/wb_mem_model.sv
`timescale 1ns/10ps

module wb_mem_model (
    input  logic        clk_i,
    input  logic        rsn_i,
    input  logic        cyc_i,
    input  logic        stb_i,
    input  logic        we_i,
    input  logic [31:0] adr_i,
    input  logic [31:0] dat_i,
    output logic [31:0] dat_o,
    output logic        ack_o
);

    localparam int MEM_BYTES = 4096;

    logic [7:0]  mem [MEM_BYTES];
    logic        busy;      // cycle seen, wait states running
    logic [1:0]  wait_cnt;
    logic [11:0] base;

    // upper address bits are folded in so aliased lines hold different bytes
    function automatic logic [7:0] init_byte(input int addr);
        return 8'(addr + (addr >> 8) + 'h5a);
    endfunction

    initial begin
        for (int a = 0; a < MEM_BYTES; a++) begin
            mem[a] <= init_byte(a);
        end
    end

    assign base = {adr_i[11:2], 2'b00};  // word aligned, 4 KiB wrap

    always @(posedge clk_i or negedge rsn_i) begin
        if (!rsn_i) begin
            ack_o    <= 1'b0;
            busy     <= 1'b0;
            wait_cnt <= '0;
            dat_o    <= '0;
        end else if (ack_o) begin
            ack_o <= 1'b0;  // master drops stb at this edge
        end else if (cyc_i && stb_i) begin
            if (!busy) begin
                busy     <= 1'b1;
                wait_cnt <= 2'($urandom_range(0, 3));
            end else if (wait_cnt != 2'd0) begin
                wait_cnt <= wait_cnt - 2'd1;
            end else begin
                busy  <= 1'b0;
                ack_o <= 1'b1;
                for (int b = 0; b < 4; b++) begin
                    if (we_i) begin
                        mem[base + 12'(b)] <= dat_i[8*b +: 8];
                    end
                end
                dat_o <= {mem[base + 12'd3], mem[base + 12'd2], mem[base + 12'd1], mem[base]};
            end
        end
    end

endmodule : wb_mem_model

// File: bench/dcache_checker.sv
`timescale 1ns/10ps

module dcache_checker (
    input logic        clk_i,
    input logic        rsn_i,
    input logic        cpu_cyc_i,
    input logic        cpu_stb_i,
    input logic        cpu_ack_i,
    input logic        mem_cyc_i,
    input logic        mem_stb_i,
    input logic        mem_we_i,
    input logic [31:0] mem_adr_i,
    input logic [31:0] mem_dat_i,
    input logic        mem_ack_i
);

    int unsigned assert_fails = 0;  // read by the testbench at the end

    //////////////////////////////////////////////////
    // cpu port
    //////////////////////////////////////////////////

    ack_in_cycle: assert property (@(posedge clk_i) disable iff (!rsn_i)
        cpu_ack_i |-> cpu_cyc_i && cpu_stb_i)
        else begin
            $error("cpu ack outside a bus cycle");
            assert_fails++;
        end

    ack_single: assert property (@(posedge clk_i) disable iff (!rsn_i)
        cpu_ack_i |=> !cpu_ack_i)
        else begin
            $error("cpu ack held for two cycles");
            assert_fails++;
        end

    //////////////////////////////////////////////////
    // memory port
    //////////////////////////////////////////////////

    stb_with_cyc: assert property (@(posedge clk_i) disable iff (!rsn_i)
        mem_stb_i |-> mem_cyc_i)
        else begin
            $error("memory stb without cyc");
            assert_fails++;
        end

    // request must hold still until the slave answers
    mem_req_stable: assert property (@(posedge clk_i) disable iff (!rsn_i)
        mem_stb_i && !mem_ack_i |=> mem_stb_i && $stable(mem_adr_i) &&
                                    $stable(mem_we_i) && $stable(mem_dat_i))
        else begin
            $error("memory request changed before ack");
            assert_fails++;
        end

endmodule : dcache_checker

bind dcache_top dcache_checker u_checker (
    .clk_i(clk_i),
    .rsn_i(rsn_i),
    .cpu_cyc_i(cpu_cyc_i),
    .cpu_stb_i(cpu_stb_i),
    .cpu_ack_i(cpu_ack_o),
    .mem_cyc_i(mem_cyc_o),
    .mem_stb_i(mem_stb_o),
    .mem_we_i(mem_we_o),
    .mem_adr_i(mem_adr_o),
    .mem_dat_i(mem_dat_o),
    .mem_ack_i(mem_ack_i)
);

// File: bench/dcache_tb.sv
`timescale 1ns/10ps

module dcache_tb import cache_pkg::*; import memop_pkg::*; ();

    localparam int          GOLDEN_BYTES = 4096;
    localparam int          ACK_TIMEOUT  = 200;
    localparam int          HIT_LATENCY  = 2;
    localparam int          RESET_CYCLES = 10;
    localparam int          RANDOM_TESTS = 20;
    localparam logic [31:0] SEED         = 32'h2b642fe1;

    logic                 clk_i;
    logic                 rsn_i;
    logic                 cpu_cyc_i;
    logic                 cpu_stb_i;
    logic                 cpu_we_i;
    logic [WORD_SIZE-1:0] cpu_adr_i;
    logic [WORD_SIZE-1:0] cpu_dat_i;
    memop_size_e          cpu_size_i;
    logic                 cpu_ack_o;
    logic [WORD_SIZE-1:0] cpu_dat_o;
    logic                 mem_cyc;
    logic                 mem_stb;
    logic                 mem_we;
    logic [WORD_SIZE-1:0] mem_adr;
    logic [WORD_SIZE-1:0] mem_wdat;
    logic [WORD_SIZE-1:0] mem_rdat;
    logic                 mem_ack;

    logic [7:0]  golden [GOLDEN_BYTES];  // what memory should hold
    string       names[$];               // stimulus table, one column per queue
    bit          wes[$];
    memop_size_e sizes[$];
    logic [31:0] addrs[$];
    logic [31:0] wdats[$];
    bit          hits[$];                // entry must hit, latency is checked
    int          tests_run = 0;
    int          errors    = 0;
    bit          timed_out = 1'b0;

    always #4 clk_i = ~clk_i;

    dcache_top uut (
        .clk_i(clk_i),
        .rsn_i(rsn_i),
        .cpu_cyc_i(cpu_cyc_i),
        .cpu_stb_i(cpu_stb_i),
        .cpu_we_i(cpu_we_i),
        .cpu_adr_i(cpu_adr_i),
        .cpu_dat_i(cpu_dat_i),
        .cpu_size_i(cpu_size_i),
        .cpu_ack_o(cpu_ack_o),
        .cpu_dat_o(cpu_dat_o),
        .mem_cyc_o(mem_cyc),
        .mem_stb_o(mem_stb),
        .mem_we_o(mem_we),
        .mem_adr_o(mem_adr),
        .mem_dat_o(mem_wdat),
        .mem_dat_i(mem_rdat),
        .mem_ack_i(mem_ack)
    );

    wb_mem_model u_mem (
        .clk_i(clk_i),
        .rsn_i(rsn_i),
        .cyc_i(mem_cyc),
        .stb_i(mem_stb),
        .we_i(mem_we),
        .adr_i(mem_adr),
        .dat_i(mem_wdat),
        .dat_o(mem_rdat),
        .ack_o(mem_ack)
    );

    //////////////////////////////////////////////////
    // golden memory
    //////////////////////////////////////////////////

    function automatic logic [7:0] preload_byte(input int addr);
        return 8'(addr + (addr >> 8) + 'h5a);
    endfunction

    function automatic int size_bytes(input memop_size_e size);
        case (size)
            MEM_BYTE: return 1;
            MEM_HALF: return 2;
            default:  return 4;
        endcase
    endfunction

    function automatic logic [31:0] golden_load(input logic [31:0] addr, input memop_size_e size);
        logic [31:0] value;
        value = '0;  // zero extension
        for (int b = 0; b < size_bytes(size); b++) begin
            value[8*b +: 8] = golden[int'(addr[11:0]) + b];
        end
        return value;
    endfunction

    task automatic store_golden(input logic [31:0] addr, input memop_size_e size,
                                input logic [31:0] data);
        for (int b = 0; b < size_bytes(size); b++) begin
            golden[int'(addr[11:0]) + b] = data[8*b +: 8];  // little endian
        end
    endtask

    //////////////////////////////////////////////////
    // stimulus table
    //////////////////////////////////////////////////

    task automatic add_entry(input string name, input bit we, input memop_size_e size,
                             input logic [31:0] addr, input logic [31:0] data, input bit hit);
        names.push_back(name);
        wes.push_back(we);
        sizes.push_back(size);
        addrs.push_back(addr);
        wdats.push_back(data);
        hits.push_back(hit);
    endtask

    task automatic build_table();
        int          a;
        int          n;
        memop_size_e size;
        add_entry("cold_load",   1'b0, MEM_WORD, 32'h040, 32'h0, 1'b0);
        add_entry("same_line",   1'b0, MEM_WORD, 32'h048, 32'h0, 1'b1);
        add_entry("st_word",     1'b1, MEM_WORD, 32'h080, 32'h11223344, 1'b0);
        add_entry("st_byte",     1'b1, MEM_BYTE, 32'h081, 32'h000000ab, 1'b1);
        add_entry("st_half",     1'b1, MEM_HALF, 32'h082, 32'h0000cdef, 1'b1);
        add_entry("ld_merged",   1'b0, MEM_WORD, 32'h080, 32'h0, 1'b1);
        add_entry("ld_byte3",    1'b0, MEM_BYTE, 32'h083, 32'h0, 1'b1);
        add_entry("ld_half0",    1'b0, MEM_HALF, 32'h080, 32'h0, 1'b1);
        add_entry("st_dirty",    1'b1, MEM_WORD, 32'h0c4, 32'hdeadbeef, 1'b0);
        add_entry("ld_evict",    1'b0, MEM_WORD, 32'h1c4, 32'h0, 1'b0);  // same index
        add_entry("ld_back",     1'b0, MEM_WORD, 32'h0c4, 32'h0, 1'b0);
        add_entry("st_alloc",    1'b1, MEM_BYTE, 32'h2d5, 32'h00000077, 1'b0);
        add_entry("ld_alloc_w0", 1'b0, MEM_WORD, 32'h2d4, 32'h0, 1'b1);
        add_entry("ld_alloc_w3", 1'b0, MEM_WORD, 32'h2dc, 32'h0, 1'b1);
        for (int i = 0; i < RANDOM_TESTS; i++) begin
            size = memop_size_e'($urandom_range(0, 2));
            n    = size_bytes(size);
            a    = $urandom_range(0, GOLDEN_BYTES - 1);
            a    = a - (a % n);  // aligned
            add_entry($sformatf("rand_%02d", i), 1'($urandom_range(0, 1)), size,
                      32'(a), $urandom(), 1'b0);
        end
    endtask

    //////////////////////////////////////////////////
    // one cpu access
    //////////////////////////////////////////////////

    task automatic run_access(input int idx);
        int          cycles;
        bit          acked;
        logic [31:0] expected;
        logic [31:0] got;
        @(posedge clk_i);
        cpu_cyc_i  <= 1'b1;
        cpu_stb_i  <= 1'b1;
        cpu_we_i   <= wes[idx];
        cpu_adr_i  <= addrs[idx];
        cpu_dat_i  <= wdats[idx];
        cpu_size_i <= sizes[idx];
        cycles = 0;
        acked  = 1'b0;
        while (!acked && cycles < ACK_TIMEOUT) begin
            @(negedge clk_i);
            cycles++;
            acked = cpu_ack_o;
        end
        got = cpu_dat_o;
        @(posedge clk_i);
        cpu_cyc_i <= 1'b0;  // one cycle after the ack
        cpu_stb_i <= 1'b0;
        tests_run++;
        expected = golden_load(addrs[idx], sizes[idx]);
        if (!acked) begin
            $display("%s: no acknowledge from cache within %0d cycles", names[idx], ACK_TIMEOUT);
            errors++;
            timed_out = 1'b1;
        end else begin
            if (wes[idx]) begin
                store_golden(addrs[idx], sizes[idx], wdats[idx]);
            end
            // first negedge is still before the sampling edge
            if (!wes[idx] && got !== expected) begin
                $display("MISMATCH %s expected 0x%08h actual 0x%08h", names[idx], expected, got);
                errors++;
            end else if (hits[idx] && (cycles - 2) != HIT_LATENCY) begin
                $display("MISMATCH %s latency expected %0d actual %0d",
                         names[idx], HIT_LATENCY, cycles - 2);
                errors++;
            end else begin
                $display("ok %-12s %s 0x%03h", names[idx], wes[idx] ? "store" : "load ",
                         addrs[idx][11:0]);
            end
        end
    endtask

    initial begin
        clk_i      = 1'b0;
        rsn_i      = 1'b0;
        cpu_cyc_i  = 1'b0;
        cpu_stb_i  = 1'b0;
        cpu_we_i   = 1'b0;
        cpu_adr_i  = '0;
        cpu_dat_i  = '0;
        cpu_size_i = MEM_WORD;
        void'($urandom(SEED));
        for (int a = 0; a < GOLDEN_BYTES; a++) begin
            golden[a] = preload_byte(a);
        end
        build_table();
        repeat (RESET_CYCLES) @(posedge clk_i);
        rsn_i <= 1'b1;
        for (int i = 0; i < names.size(); i++) begin
            if (!timed_out) begin
                run_access(i);
            end
        end
        repeat (2) @(posedge clk_i);
        errors += int'(uut.u_checker.assert_fails);
        $display("tests run %0d, errors %0d", tests_run, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule : dcache_tb

// File: filelist.f
src/cache_pkg.sv
src/memop_pkg.sv
src/cache_tags.sv
src/cache_data.sv
src/cache_ctrl.sv
src/wb_line_master.sv
src/dcache_top.sv
bench/wb_mem_model.sv
bench/dcache_checker.sv
bench/dcache_tb.sv

// File: Makefile
# Verilator build and run of the data cache testbench

VERILATOR ?= verilator
TOP       ?= dcache_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf $(OBJ_DIR)
